// File: verilog/fetch_params.svh
// fetch subsystem constants, included by the modules that size buffers or reset trap vectors
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ------------------------------------------------------------
// prefetch buffer
// ------------------------------------------------------------

// words held in the queue plus words still in flight
`define FETCH_BUF_DEPTH 4

// ------------------------------------------------------------
// reset values of the trap vector registers
// ------------------------------------------------------------

// all addresses are word aligned, low bits dropped on storage
`define FETCH_BOOT_ADDR   32'h0000_0080
`define FETCH_MTVEC_RST   32'h0000_1000
`define FETCH_UTVEC_RST   32'h0000_2000
`define FETCH_DM_HALT_RST 32'h0000_0800

// instruction memory answers with an error from here upward
`define FETCH_ERR_BASE    32'h0008_0000

`endif

// File: verilog/fetch_pkg.sv
// shared fetch types, imported by the fetch RTL and its testbench
`default_nettype none

package fetch_pkg;

  // ------------------------------------------------------------
  // select encodings
  // ------------------------------------------------------------

  // next pc source
  typedef enum logic [3:0] {
    PC_BOOT      = 4'd0,
    PC_JUMP      = 4'd1,
    PC_BRANCH    = 4'd2,
    PC_EXCEPTION = 4'd3,
    PC_MRET      = 4'd4,
    PC_DRET      = 4'd5,
    PC_FENCEI    = 4'd6,
    PC_HWLOOP    = 4'd7
  } pc_mux_e;

  // handler kind when pc_mux selects the exception pc
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_DBG       = 2'd2
  } exc_pc_mux_e;

  // privilege mode picks the trap base
  typedef enum logic {
    TRAP_MACHINE = 1'b0,
    TRAP_USER    = 1'b1
  } trap_mode_e;

  // config port register select
  typedef enum logic [1:0] {
    CFG_MTVEC  = 2'd0,
    CFG_UTVEC  = 2'd1,
    CFG_BOOT   = 2'd2,
    CFG_DMHALT = 2'd3
  } cfg_addr_e;

  // ------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------

  // bases keep [31:8], boot and halt keep [31:2]
  typedef struct packed {
    logic [23:0] m_base;
    logic [23:0] u_base;
    logic [29:0] boot;
    logic [29:0] dm_halt;
  } trap_cfg_t;

  // redirect request from the controller
  typedef struct packed {
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    trap_mode_e  trap_mode;
    logic [5:0]  irq_id;
  } redirect_t;

  // one fetched word tagged with its address
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        fetch_failed;
  } id_out_t;

endpackage

`default_nettype wire

// File: verilog/trap_vector_regs.sv
// writable trap base, boot and debug halt registers feeding the IF stage address muxes
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module trap_vector_regs
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_we_i,
  input  cfg_addr_e   cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  output trap_cfg_t   trap_cfg_o
);

  // full reset words, sliced below to the stored bits
  localparam logic [31:0] MTVEC_RST   = `FETCH_MTVEC_RST;
  localparam logic [31:0] UTVEC_RST   = `FETCH_UTVEC_RST;
  localparam logic [31:0] BOOT_RST    = `FETCH_BOOT_ADDR;
  localparam logic [31:0] DM_HALT_RST = `FETCH_DM_HALT_RST;

  trap_cfg_t cfg_q;

  // write lands at the edge closing the strobe cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.m_base  <= MTVEC_RST[31:8];
      cfg_q.u_base  <= UTVEC_RST[31:8];
      cfg_q.boot    <= BOOT_RST[31:2];
      cfg_q.dm_halt <= DM_HALT_RST[31:2];
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        // trap bases are 256 byte aligned
        CFG_MTVEC:  cfg_q.m_base  <= cfg_wdata_i[31:8];
        CFG_UTVEC:  cfg_q.u_base  <= cfg_wdata_i[31:8];
        // boot and halt are word aligned
        CFG_BOOT:   cfg_q.boot    <= cfg_wdata_i[31:2];
        CFG_DMHALT: cfg_q.dm_halt <= cfg_wdata_i[31:2];
        default:    cfg_q         <= cfg_q;
      endcase
    end
  end

  assign trap_cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: verilog/prefetch_buffer.sv
// prefetch buffer between the IF stage and instruction memory, req/gnt/rvalid on the memory side
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module prefetch_buffer
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_i,
  input  logic         branch_i,
  input  logic [31:0]  branch_addr_i,
  input  logic         pop_i,
  output logic         entry_valid_o,
  output fetch_entry_t entry_o,
  output logic         instr_req_o,
  output logic [31:0]  instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  logic [31:0]  instr_rdata_i,
  input  logic         instr_err_i,
  output logic         busy_o
);

  localparam int DEPTH = `FETCH_BUF_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  // ------------------------------------------------------------
  // state
  // ------------------------------------------------------------

  logic          started_q;
  logic          hang_q;
  logic          pend_q;
  logic [31:0]   fetch_addr_q;
  logic [31:0]   pend_addr_q;
  logic [31:0]   rsp_addr_q;
  logic [CW-1:0] out_cnt_q;
  logic [CW-1:0] out_cnt_n;
  logic [CW-1:0] drop_cnt_q;
  logic [CW-1:0] drop_cnt_n;
  logic [CW-1:0] count_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  logic [CW:0]   level;
  logic          space;
  logic          gnt;
  logic          resp_drop;
  logic          push;
  logic          pop;

  fetch_entry_t  mem [DEPTH];

  // in flight words (stale ones too) plus stored words bound the queue
  assign level = out_cnt_q + count_q;
  assign space = level < DEPTH;

  // an ungranted request stays up with its address until accepted
  assign instr_req_o  = hang_q | (started_q & req_i & space);
  assign instr_addr_o = fetch_addr_q;
  assign gnt          = instr_req_o & instr_gnt_i;

  // responses of requests granted before a redirect are swallowed
  assign resp_drop = instr_rvalid_i & (drop_cnt_q != '0);
  assign push      = instr_rvalid_i & ~resp_drop & ~branch_i;
  assign pop       = pop_i & (count_q != '0);

  always_comb begin
    out_cnt_n = out_cnt_q + CW'(gnt) - CW'(instr_rvalid_i);
    if (branch_i) begin
      // everything still in flight after this edge is stale
      drop_cnt_n = out_cnt_n;
    end else begin
      // a hanging pre-redirect request becomes stale once granted
      drop_cnt_n = drop_cnt_q + CW'(gnt & pend_q) - CW'(resp_drop);
    end
  end

  // ------------------------------------------------------------
  // control and address tracking
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q    <= 1'b0;
      hang_q       <= 1'b0;
      pend_q       <= 1'b0;
      fetch_addr_q <= '0;
      pend_addr_q  <= '0;
      rsp_addr_q   <= '0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      count_q      <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      hang_q     <= instr_req_o & ~instr_gnt_i;
      out_cnt_q  <= out_cnt_n;
      drop_cnt_q <= drop_cnt_n;
      if (branch_i) begin
        started_q  <= 1'b1;
        rsp_addr_q <= branch_addr_i;
        count_q    <= '0;
        rd_ptr_q   <= '0;
        wr_ptr_q   <= '0;
        if (instr_req_o & ~instr_gnt_i) begin
          // old address must hold until its grant
          pend_q      <= 1'b1;
          pend_addr_q <= branch_addr_i;
        end else begin
          pend_q       <= 1'b0;
          fetch_addr_q <= branch_addr_i;
        end
      end else begin
        if (gnt) begin
          if (pend_q) begin
            fetch_addr_q <= pend_addr_q;
            pend_q       <= 1'b0;
          end else begin
            fetch_addr_q <= fetch_addr_q + 32'd4;
          end
        end
        if (push) begin
          wr_ptr_q   <= wr_ptr_q + 1'b1;
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        count_q <= count_q + CW'(push) - CW'(pop);
      end
    end
  end

  // word storage, tag taken from the running response address
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= '{rdata: instr_rdata_i, addr: rsp_addr_q, err: instr_err_i};
    end
  end

  assign entry_valid_o = count_q != '0;
  assign entry_o       = mem[rd_ptr_q];
  assign busy_o        = instr_req_o | (out_cnt_q != '0);

endmodule

`default_nettype wire

// File: verilog/if_stage.sv
// IF stage with next pc and exception pc selection, the issue FSM and the IF/ID register, used in fetch_top
`timescale 1ns/1ps
`default_nettype none

module if_stage
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_i,
  input  trap_cfg_t    trap_cfg_i,
  input  redirect_t    redirect_i,
  input  logic [31:0]  jump_target_i,
  input  logic [31:0]  branch_target_i,
  input  logic [31:0]  epc_i,
  input  logic [31:0]  depc_i,
  input  logic [31:0]  hwloop_target_i,
  input  logic         halt_i,
  input  logic         id_ready_i,
  input  logic         entry_valid_i,
  input  fetch_entry_t entry_i,
  output logic         branch_o,
  output logic [31:0]  branch_addr_o,
  output logic         pop_o,
  output logic [31:0]  target_o,
  output id_out_t      id_o,
  output logic         imiss_o
);

  typedef enum logic {IDLE, WAIT} state_e;

  state_e      state_q;
  state_e      state_n;
  logic [23:0] trap_base;
  logic [31:0] exc_pc;
  logic [31:0] fetch_addr_n;
  logic [31:0] boot_addr;
  logic        valid;
  logic        if_valid;
  logic        id_valid_q;
  logic        id_failed_q;
  logic [31:0] id_rdata_q;
  logic [31:0] id_addr_q;

  // ------------------------------------------------------------
  // address selection
  // ------------------------------------------------------------

  assign boot_addr = {trap_cfg_i.boot, 2'b00};

  always_comb begin
    trap_base = (redirect_i.trap_mode == TRAP_USER) ? trap_cfg_i.u_base : trap_cfg_i.m_base;
    case (redirect_i.exc_pc_mux)
      // synchronous exceptions share the base
      EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};
      // vectored interrupts get one word per id and lose the top base bit
      EXC_PC_IRQ:       exc_pc = {trap_base[22:0], 1'b0, redirect_i.irq_id, 2'b00};
      EXC_PC_DBG:       exc_pc = {trap_cfg_i.dm_halt, 2'b00};
      default:          exc_pc = {trap_base, 8'h00};
    endcase
  end

  always_comb begin
    case (redirect_i.pc_mux)
      PC_BOOT:      fetch_addr_n = boot_addr;
      PC_JUMP:      fetch_addr_n = jump_target_i;
      PC_BRANCH:    fetch_addr_n = branch_target_i;
      PC_EXCEPTION: fetch_addr_n = exc_pc;
      PC_MRET:      fetch_addr_n = epc_i;
      PC_DRET:      fetch_addr_n = depc_i;
      // refetch after the instruction sitting in ID
      PC_FENCEI:    fetch_addr_n = id_addr_q + 32'd4;
      PC_HWLOOP:    fetch_addr_n = hwloop_target_i;
      default:      fetch_addr_n = boot_addr;
    endcase
  end

  assign target_o = fetch_addr_n;

  // first fetch after req_i starts at the boot address
  assign branch_addr_o = redirect_i.pc_set ? {fetch_addr_n[31:2], 2'b00} : boot_addr;

  // ------------------------------------------------------------
  // issue FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  always_comb begin
    state_n  = state_q;
    branch_o = 1'b0;
    valid    = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          branch_o = 1'b1;
          state_n  = WAIT;
        end
      end
      WAIT: begin
        valid = entry_valid_i;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
    // a redirect wins since the offered entry belongs to the old stream
    if (redirect_i.pc_set) begin
      branch_o = 1'b1;
      valid    = 1'b0;
      state_n  = WAIT;
    end
  end

  assign if_valid = valid & id_ready_i & ~halt_i;
  assign pop_o    = if_valid;
  assign imiss_o  = ~entry_valid_i | branch_o;

  // ------------------------------------------------------------
  // IF/ID register
  // ------------------------------------------------------------

  // ID consumes the held word when ready and not halted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q  <= 1'b0;
      id_failed_q <= 1'b0;
    end else if (redirect_i.pc_set) begin
      id_valid_q <= 1'b0;
    end else if (if_valid) begin
      id_valid_q  <= 1'b1;
      id_failed_q <= entry_i.err;
    end else if (id_ready_i && !halt_i) begin
      id_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      id_rdata_q <= entry_i.rdata;
      id_addr_q  <= entry_i.addr;
    end
  end

  assign id_o = '{valid: id_valid_q, rdata: id_rdata_q, addr: id_addr_q,
                  fetch_failed: id_failed_q};

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
// instruction fetch subsystem top, trap vector registers beside the IF stage and prefetch buffer
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // config write port
  input  logic        cfg_we_i,
  input  cfg_addr_e   cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  input  logic        req_i,
  // redirect and targets
  input  redirect_t   redirect_i,
  input  logic [31:0] jump_target_i,
  input  logic [31:0] branch_target_i,
  input  logic [31:0] epc_i,
  input  logic [31:0] depc_i,
  input  logic [31:0] hwloop_target_i,
  input  logic        halt_i,
  input  logic        id_ready_i,
  // instruction memory
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,
  // decode side and status
  output id_out_t     id_o,
  output logic [31:0] target_o,
  output logic        busy_o,
  output logic        imiss_o
);

  trap_cfg_t    trap_cfg;
  logic         branch;
  logic [31:0]  branch_addr;
  logic         pop;
  logic         entry_valid;
  fetch_entry_t entry;

  trap_vector_regs i_trap_vector_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .trap_cfg_o (trap_cfg)
  );

  if_stage i_if_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .trap_cfg_i     (trap_cfg),
    .redirect_i     (redirect_i),
    .jump_target_i  (jump_target_i),
    .branch_target_i(branch_target_i),
    .epc_i          (epc_i),
    .depc_i         (depc_i),
    .hwloop_target_i(hwloop_target_i),
    .halt_i         (halt_i),
    .id_ready_i     (id_ready_i),
    .entry_valid_i  (entry_valid),
    .entry_i        (entry),
    .branch_o       (branch),
    .branch_addr_o  (branch_addr),
    .pop_o          (pop),
    .target_o       (target_o),
    .id_o           (id_o),
    .imiss_o        (imiss_o)
  );

  prefetch_buffer i_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .pop_i         (pop),
    .entry_valid_o (entry_valid),
    .entry_o       (entry),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .busy_o        (busy_o)
  );

endmodule

`default_nettype wire

// File: testbench/fetch_properties.sv
// concurrent checks on the instruction memory port and the IF/ID register, bound into fetch_top
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetch_properties
  import fetch_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        req_i,
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input redirect_t   redirect_i,
  input id_out_t     id_i
);

  localparam logic [31:0] ERR_BASE = `FETCH_ERR_BASE;

  // ------------------------------------------------------------
  // memory port
  // ------------------------------------------------------------

  // memory may only grant a pending request
  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n) gnt_i |-> req_i)
    else $error("grant seen without a request");

  // a waiting request keeps its address until granted
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else $error("request dropped or address moved before its grant");

  // no compressed fetch, word addresses only
  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> (addr_i[1:0] == 2'b00))
    else $error("request address not word aligned");

  // ------------------------------------------------------------
  // IF/ID register
  // ------------------------------------------------------------

  // redirect squashes whatever ID would see next cycle
  a_squash_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i.pc_set |=> !id_i.valid)
    else $error("ID valid in the cycle after a redirect");

  // error flag tracks the error region of the memory
  a_err_region: assert property (@(posedge clk) disable iff (!rst_n)
    id_i.valid |-> (id_i.fetch_failed == (id_i.addr >= ERR_BASE)))
    else $error("fetch_failed does not match the error region");

endmodule

bind fetch_top fetch_properties i_fetch_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_i     (instr_req_o),
  .addr_i    (instr_addr_o),
  .gnt_i     (instr_gnt_i),
  .redirect_i(redirect_i),
  .id_i      (id_o)
);

`default_nettype wire

// File: testbench/fetch_tb.sv
// self-checking testbench for fetch_top with a memory responder and an address model, run as top
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  // rough sum of all tests where the back-pressure run dominates
  localparam int TEST_CYCLES = 2500;
  localparam logic [31:0] ERR_BASE = `FETCH_ERR_BASE;

  logic        clk;
  logic        rst_n;
  logic        cfg_we_i;
  cfg_addr_e   cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic        req_i;
  redirect_t   redirect_i;
  logic [31:0] jump_target_i;
  logic [31:0] branch_target_i;
  logic [31:0] epc_i;
  logic [31:0] depc_i;
  logic [31:0] hwloop_target_i;
  logic        halt_i;
  logic        id_ready_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  id_out_t     id_o;
  logic [31:0] target_o;
  logic        busy_o;
  logic        imiss_o;

  // model state
  logic [31:0] stim_rng;
  logic [31:0] mem_rng;
  logic [31:0] exp_addr;
  logic [31:0] model_mtvec;
  logic [31:0] model_utvec;
  logic [31:0] model_boot;
  logic [31:0] model_dmhalt;
  int          n_checks;
  int          n_errors;
  int          n_accepted;
  int          n_failed_seen;
  int          test_checks0;
  int          test_errors0;

  fetch_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .req_i          (req_i),
    .redirect_i     (redirect_i),
    .jump_target_i  (jump_target_i),
    .branch_target_i(branch_target_i),
    .epc_i          (epc_i),
    .depc_i         (depc_i),
    .hwloop_target_i(hwloop_target_i),
    .halt_i         (halt_i),
    .id_ready_i     (id_ready_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .id_o           (id_o),
    .target_o       (target_o),
    .busy_o         (busy_o),
    .imiss_o        (imiss_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    // hand out the upper bits since the low LCG bits cycle fast
    return {8'h00, state[31:8]};
  endfunction

  // memory word is the address xor a fixed pattern rotated left by 3
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'hA5A5_0000;
    return (x << 3) | (x >> 29);
  endfunction

  function automatic logic [31:0] rand_addr();
    return lcg_next(stim_rng) & 32'h0003_FFFC;
  endfunction

  // target the redirect should land on given the written trap registers
  function automatic logic [31:0] model_target(input redirect_t rd);
    logic [31:0] base;
    base = (rd.trap_mode == TRAP_USER) ? model_utvec : model_mtvec;
    case (rd.pc_mux)
      PC_JUMP:   return jump_target_i;
      PC_BRANCH: return branch_target_i;
      PC_MRET:   return epc_i;
      PC_DRET:   return depc_i;
      PC_HWLOOP: return hwloop_target_i;
      // word after the one held in ID
      PC_FENCEI: return exp_addr + 32'd4;
      PC_EXCEPTION: begin
        // vector table sits one bit above the id field and bit 31 of the base drops out
        if (rd.exc_pc_mux == EXC_PC_IRQ) begin
          return ((base & 32'hFFFF_FF00) << 1) | (32'(rd.irq_id) << 2);
        end else if (rd.exc_pc_mux == EXC_PC_DBG) begin
          return model_dmhalt & 32'hFFFF_FFFC;
        end else begin
          return base & 32'hFFFF_FF00;
        end
      end
      default:   return model_boot & 32'hFFFF_FFFC;
    endcase
  endfunction

  task automatic check_low(input string name, input logic got);
    n_checks++;
    if (got !== 1'b0) begin
      $display("CHECK FAILED %s expected 0 got %h", name, got);
      n_errors++;
    end
  endtask

  task automatic check_reset_outputs();
    check_low("instr_req_o", instr_req_o);
    check_low("id_o.valid", id_o.valid);
    check_low("id_o.fetch_failed", id_o.fetch_failed);
    check_low("busy_o", busy_o);
  endtask

  // word in ID against the expected address and the memory rule
  task automatic check_id(input logic [31:0] exp);
    logic [31:0] exp_data;
    logic        exp_err;
    exp_data = mem_word(exp);
    exp_err  = exp >= ERR_BASE;
    n_checks++;
    if (id_o.addr !== exp) begin
      $display("CHECK FAILED id_o.addr expected %h got %h", exp, id_o.addr);
      n_errors++;
    end
    if (id_o.rdata !== exp_data) begin
      $display("CHECK FAILED id_o.rdata expected %h got %h", exp_data, id_o.rdata);
      n_errors++;
    end
    if (id_o.fetch_failed !== exp_err) begin
      $display("CHECK FAILED id_o.fetch_failed expected %h got %h", exp_err, id_o.fetch_failed);
      n_errors++;
    end
    if (id_o.fetch_failed) begin
      n_failed_seen++;
    end
  endtask

  // one cycle entered and left 1 ns after the rising edge
  task automatic drive_cycle(input logic rdy, input logic hlt, input redirect_t rd,
                             input logic [31:0] tgt);
    if (id_o.valid) begin
      if (rd.pc_set) begin
        // squashed word must still be the expected one
        check_id(exp_addr);
      end else if (rdy && !hlt) begin
        check_id(exp_addr);
        exp_addr = exp_addr + 32'd4;
        n_accepted++;
      end
    end
    id_ready_i = rdy;
    halt_i     = hlt;
    redirect_i = rd;
    if (rd.pc_set) begin
      exp_addr = tgt;
      #1;
      n_checks++;
      if (target_o !== tgt) begin
        $display("CHECK FAILED target_o expected %h got %h", tgt, target_o);
        n_errors++;
      end
      // a branch in progress always counts as a miss
      n_checks++;
      if (imiss_o !== 1'b1) begin
        $display("CHECK FAILED imiss_o expected 1 got %h", imiss_o);
        n_errors++;
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_instrs(input int count, input int max_cycles, input logic stall);
    int          goal;
    int          cycles;
    logic        rdy;
    logic        hlt;
    logic [31:0] r;
    goal   = n_accepted + count;
    cycles = 0;
    while (n_accepted < goal && cycles < max_cycles) begin
      rdy = 1'b1;
      hlt = 1'b0;
      if (stall) begin
        r   = lcg_next(stim_rng);
        rdy = (r % 4) != 0;
        hlt = r[9:7] == 3'd0;
      end
      drive_cycle(rdy, hlt, '0, 32'd0);
      cycles++;
    end
    if (n_accepted < goal) begin
      $display("timeout: only %0d of %0d instructions reached decode in %0d cycles",
               count - (goal - n_accepted), count, max_cycles);
      n_errors++;
    end
  endtask

  task automatic wait_id_valid();
    int cycles;
    cycles = 0;
    while (!id_o.valid && cycles < 100) begin
      drive_cycle(1'b1, 1'b0, '0, 32'd0);
      cycles++;
    end
    if (!id_o.valid) begin
      $display("timeout: no instruction showed up in ID before the fence redirect");
      n_errors++;
    end
  endtask

  task automatic issue_redirect(input redirect_t rd);
    drive_cycle(1'b1, 1'b0, rd, model_target(rd));
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    case (addr)
      CFG_MTVEC: model_mtvec  = data;
      CFG_UTVEC: model_utvec  = data;
      CFG_BOOT:  model_boot   = data;
      default:   model_dmhalt = data;
    endcase
    drive_cycle(1'b1, 1'b0, '0, 32'd0);
    cfg_we_i = 1'b0;
  endtask

  task automatic start_test();
    test_checks0 = n_checks;
    test_errors0 = n_errors;
  endtask

  task automatic end_test(input string name);
    $display("test %-14s done: %0d checks, %0d errors", name,
             n_checks - test_checks0, n_errors - test_errors0);
  endtask

  // ------------------------------------------------------------
  // instruction memory
  // ------------------------------------------------------------

  initial begin : memory_model
    logic [31:0] rsp_q[$];
    logic [31:0] raddr;
    logic        give;
    mem_rng        = 32'd43;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'd0;
    instr_err_i    = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      // in order answers come one cycle after the grant at the earliest
      if (rsp_q.size() > 0 && (lcg_next(mem_rng) % 3) != 0) begin
        raddr          = rsp_q.pop_front();
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(raddr);
        instr_err_i    = raddr >= ERR_BASE;
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = 32'd0;
        instr_err_i    = 1'b0;
      end
      // random grant delay applies only to a pending request
      give        = instr_req_o && ((lcg_next(mem_rng) % 4) != 0);
      instr_gnt_i = give;
      if (give) begin
        rsp_q.push_back(instr_addr_o);
      end
    end
  end

  initial begin : watchdog
    #(TEST_CYCLES * 20 * CLK_PERIOD);
    $display("watchdog expired after %0d clock cycles", TEST_CYCLES * 20);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin : stimulus
    int          i;
    int          failed0;
    logic [31:0] r;
    redirect_t   rd;
    stim_rng        = 32'd43;
    rst_n           = 1'b0;
    cfg_we_i        = 1'b0;
    cfg_addr_i      = CFG_MTVEC;
    cfg_wdata_i     = 32'd0;
    req_i           = 1'b0;
    redirect_i      = '0;
    jump_target_i   = 32'd0;
    branch_target_i = 32'd0;
    epc_i           = 32'd0;
    depc_i          = 32'd0;
    hwloop_target_i = 32'd0;
    halt_i          = 1'b0;
    id_ready_i      = 1'b0;
    model_mtvec     = `FETCH_MTVEC_RST;
    model_utvec     = `FETCH_UTVEC_RST;
    model_boot      = `FETCH_BOOT_ADDR;
    model_dmhalt    = `FETCH_DM_HALT_RST;
    n_checks        = 0;
    n_errors        = 0;
    n_accepted      = 0;
    n_failed_seen   = 0;

    // outputs quiet through reset and just after
    start_test();
    repeat (10) begin
      @(posedge clk);
      #1;
      check_reset_outputs();
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #1;
      check_reset_outputs();
    end
    end_test("reset state");

    start_test();
    exp_addr = `FETCH_BOOT_ADDR;
    req_i    = 1'b1;
    run_instrs(16, 300, 1'b0);
    end_test("boot fetch");

    // every non trap source in turn with random targets and spacing
    start_test();
    for (i = 0; i < 24; i++) begin
      jump_target_i   = rand_addr();
      branch_target_i = rand_addr();
      epc_i           = rand_addr();
      depc_i          = rand_addr();
      hwloop_target_i = rand_addr();
      rd        = '0;
      rd.pc_set = 1'b1;
      case (i % 6)
        0:       rd.pc_mux = PC_JUMP;
        1:       rd.pc_mux = PC_BRANCH;
        2:       rd.pc_mux = PC_MRET;
        3:       rd.pc_mux = PC_DRET;
        4:       rd.pc_mux = PC_FENCEI;
        default: rd.pc_mux = PC_HWLOOP;
      endcase
      if (rd.pc_mux == PC_FENCEI) begin
        wait_id_valid();
      end
      issue_redirect(rd);
      r = lcg_next(stim_rng);
      run_instrs(1 + int'(r % 4), 300, 1'b0);
    end
    end_test("redirects");

    // all handler kinds in both modes after random register writes
    start_test();
    for (i = 0; i < 24; i++) begin
      r = lcg_next(stim_rng);
      write_cfg(cfg_addr_e'(r[1:0]), lcg_next(stim_rng) & 32'h0007_FFFF);
      r            = lcg_next(stim_rng);
      rd           = '0;
      rd.pc_set    = 1'b1;
      rd.pc_mux    = PC_EXCEPTION;
      rd.trap_mode = ((i / 3) % 2 == 1) ? TRAP_USER : TRAP_MACHINE;
      rd.irq_id    = r[5:0];
      case (i % 3)
        0:       rd.exc_pc_mux = EXC_PC_EXCEPTION;
        1:       rd.exc_pc_mux = EXC_PC_IRQ;
        default: rd.exc_pc_mux = EXC_PC_DBG;
      endcase
      issue_redirect(rd);
      run_instrs(2, 300, 1'b0);
    end
    write_cfg(CFG_BOOT, rand_addr());
    rd        = '0;
    rd.pc_set = 1'b1;
    rd.pc_mux = PC_BOOT;
    issue_redirect(rd);
    run_instrs(2, 300, 1'b0);
    end_test("trap vectors");

    start_test();
    run_instrs(300, 4000, 1'b1);
    end_test("back-pressure");

    // stream runs across the start of the error region and then jumps back out
    start_test();
    failed0       = n_failed_seen;
    jump_target_i = ERR_BASE - 32'd8;
    rd            = '0;
    rd.pc_set     = 1'b1;
    rd.pc_mux     = PC_JUMP;
    issue_redirect(rd);
    run_instrs(6, 300, 1'b0);
    if (n_failed_seen == failed0) begin
      $display("no failed fetch reached decode inside the error region");
      n_errors++;
    end
    jump_target_i = 32'h0000_0200;
    issue_redirect(rd);
    run_instrs(3, 300, 1'b0);
    end_test("fetch error");

    $display("total: %0d checks, %0d errors, %0d instructions", n_checks, n_errors, n_accepted);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/trap_vector_regs.sv
verilog/prefetch_buffer.sv
verilog/if_stage.sv
verilog/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the fetch testbench with Verilator, run it and look for the pass line in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fetch_tb -o fetch_sim \
  && ./obj_dir/fetch_sim 2>&1 | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
